//--- rtl/cart_pkg.sv
/*
	Cartridge-side definitions shared by the mapper, the bank table and the
	translator. Holds the CRT type numbers and the bank table geometry.
*/

package cart_pkg;

	// ****************************************
	// Cartridge type numbers from the CRT header
	// ****************************************
	typedef logic [15:0] cart_id_t;

	localparam cart_id_t CART_GENERIC    = 16'd0;
	localparam cart_id_t CART_OCEAN      = 16'd5;	// Ocean type 1
	localparam cart_id_t CART_C64GS      = 16'd15;
	localparam cart_id_t CART_MAGIC_DESK = 16'd19;
	localparam cart_id_t CART_EASYFLASH  = 16'd32;

	// ****************************************
	// Bank table geometry
	// ****************************************
	localparam int BANK_ENTRIES = 64;	// 64 banks of 8K

	typedef logic [$clog2(BANK_ENTRIES)-1:0] bank_idx_t;

	// An SDRAM page is 8K, taken from bits 19..13 of the load address
	localparam int PAGE_LSB  = 13;
	localparam int PAGE_BITS = 7;

	typedef logic [PAGE_BITS-1:0] page_t;

	// Chip packets loaded at or below $8000 belong to ROML
	localparam logic [15:0] LO_LOAD_LIMIT = 16'h8000;

	// Packets larger than one bank spill into ROMH
	localparam logic [15:0] LO_BANK_SIZE  = 16'h2000;

endpackage

//--- rtl/mem_map_pkg.sv
/*
	SDRAM address map of the cartridge image. The CRT chip packets sit in the
	ROM region, the cartridge RAM below it.
*/

package mem_map_pkg;

	typedef logic [24:0] sdram_addr_t;	// SDRAM word address
	typedef logic [17:0] cpu_addr_t;	// Address from the CPU side

	// ****************************************
	// Region bases
	// ****************************************
	localparam int ROM_BASE_BIT = 20;	// ROM banks start at 0x100000

	localparam sdram_addr_t RAM_BASE = 25'h040000;

	// ****************************************
	// Window sizes
	// ****************************************
	localparam int WIN_BITS    = 13;	// 8K ROM window
	localparam int IO_RAM_BITS = 8;	// One 256 byte I/O page

endpackage

//--- rtl/cart_ifs.sv
/*
	Interfaces inside the cartridge core. The translator looks pages up in
	the bank table, and reads the bank registers that the mapper keeps.
*/

`timescale 1ns/10ps

// Plain asynchronous read of the bank table
interface page_lookup_if import cart_pkg::*; ();

	bank_idx_t lo_idx;	// Bank shown in ROML
	bank_idx_t hi_idx;	// Bank shown in ROMH
	page_t     lo_page;
	page_t     hi_page;

	modport translator (output lo_idx, hi_idx, input lo_page, hi_page);
	modport tbl        (input lo_idx, hi_idx, output lo_page, hi_page);

endinterface

// Registered banking state of the selected cartridge type
interface bank_state_if import cart_pkg::*; ();

	bank_idx_t bank_lo;
	bank_idx_t bank_hi;
	logic      iof_ena;		// IO2 page mapped to cart RAM
	logic      iof_wr_ena;	// Writes to that RAM allowed too

	modport mapper     (output bank_lo, bank_hi, iof_ena, iof_wr_ena);
	modport translator (input bank_lo, bank_hi, iof_ena, iof_wr_ena);

endinterface

//--- rtl/bank_table.sv
/*
	Bank number to SDRAM page table. Filled by one strobe per CRT chip packet
	while the file loads, read asynchronously by the address translator.
*/

`timescale 1ns/10ps

module bank_table import cart_pkg::*; (
	input  logic        clk32,
	input  logic        cart_bank_wr,		// One cycle per chip packet
	input  logic [15:0] cart_bank_num,
	input  logic [15:0] cart_bank_laddr,	// Load address from the packet
	input  logic [15:0] cart_bank_size,
	input  logic [24:0] cart_bank_raddr,	// Where the packet landed in SDRAM
	page_lookup_if.tbl  lookup
);

	page_t     lo_pages [BANK_ENTRIES];	// ROML page per bank
	page_t     hi_pages [BANK_ENTRIES];	// ROMH page per bank

	page_t     wr_page;
	bank_idx_t wr_idx;
	logic      wr_valid;
	logic      wr_low;
	logic      wr_spill;

	assign wr_page  = cart_bank_raddr[PAGE_LSB +: PAGE_BITS];
	assign wr_idx   = bank_idx_t'(cart_bank_num);
	assign wr_valid = cart_bank_wr && (cart_bank_num < 16'(BANK_ENTRIES));
	assign wr_low   = cart_bank_laddr <= LO_LOAD_LIMIT;
	assign wr_spill = cart_bank_size > LO_BANK_SIZE;	// 16K packet covers both windows

	// ****************************************
	// Fill during load
	// ****************************************
	always_ff @(posedge clk32) begin
		if (wr_valid) begin
			if (wr_low) begin
				lo_pages[wr_idx] <= wr_page;
				if (wr_spill)
					hi_pages[wr_idx] <= wr_page + 7'd1;	// Second half of the packet
			end else begin
				hi_pages[wr_idx] <= wr_page;	// $A000 or $E000 packet
			end
		end
	end

	// Lookup for the translator, same cycle
	assign lookup.lo_page = lo_pages[lookup.lo_idx];
	assign lookup.hi_page = hi_pages[lookup.hi_idx];

endmodule

//--- rtl/cart_mapper.sv
/*
	Cartridge register logic. Watches CPU accesses to the IO1 page and keeps
	the bank numbers, the IO2 RAM enables and the EXROM/GAME lines for the
	selected cartridge type. Resets itself when the type changes.
*/

`timescale 1ns/10ps

module cart_mapper import cart_pkg::*, mem_map_pkg::*; (
	input  logic        clk32,
	input  logic        reset_n,		// Synchronous, active high
	input  cart_id_t    cart_id,
	input  logic [7:0]  cart_exrom,		// EXROM field of the CRT header
	input  logic [7:0]  cart_game,		// GAME field of the CRT header
	input  logic        ioe,
	input  logic        mem_write,
	input  cpu_addr_t   addr_in,
	input  logic [7:0]  data_in,
	output logic        exrom,
	output logic        game,
	bank_state_if.mapper state
);

	logic     old_ioe;
	cart_id_t old_id;
	logic     init_n;	// Low for the first cycle of a type
	logic     restart;
	logic     stb_ioe;
	logic     ioe_wr;
	logic     ioe_rd;

	// ****************************************
	// Access detection
	// ****************************************
	always_ff @(posedge clk32) begin
		old_ioe <= ioe;
		old_id  <= cart_id;
	end

	assign stb_ioe = ioe && !old_ioe;	// First cycle of an IO1 access
	assign ioe_wr  = stb_ioe && mem_write;
	assign ioe_rd  = stb_ioe && !mem_write;

	// A new cartridge type is handled like a reset
	assign restart = reset_n || (old_id != cart_id);

	// ****************************************
	// Per-type register state
	// ****************************************
	always_ff @(posedge clk32) begin
		init_n <= 1'b1;

		if (restart) begin
			init_n           <= 1'b0;
			exrom            <= 1'b1;	// No cartridge
			game             <= 1'b1;
			state.bank_lo    <= '0;
			state.bank_hi    <= '0;
			state.iof_ena    <= 1'b0;
			state.iof_wr_ena <= 1'b0;
		end else begin
			case (cart_id)
				// 8K, 16K or ultimax as the file says
				CART_GENERIC: begin
					exrom         <= cart_exrom[0];
					game          <= cart_game[0];
					state.bank_lo <= '0;
					state.bank_hi <= '0;
				end

				// 16K mode, bank number written to $DE00
				CART_OCEAN: begin
					exrom <= 1'b0;
					game  <= 1'b0;
					if (ioe_wr) begin
						state.bank_lo <= data_in[5:0];
						state.bank_hi <= data_in[5:0];
					end
				end

				// 8K mode, bank taken from the address of the write
				CART_C64GS: begin
					exrom <= 1'b0;
					game  <= 1'b1;
					if (ioe_rd)
						state.bank_lo <= '0;
					if (ioe_wr)
						state.bank_lo <= addr_in[5:0];
				end

				CART_MAGIC_DESK: begin
					if (!init_n) begin
						exrom         <= 1'b0;
						game          <= 1'b1;
						state.bank_lo <= '0;
					end
					if (ioe_wr) begin
						state.bank_lo <= data_in[5:0];	// Always six bank bits
						exrom         <= data_in[7];	// Bit 7 hides the cart
					end
				end

				// Boots in ultimax, 256 bytes of RAM at $DF00
				CART_EASYFLASH: begin
					if (!init_n) begin
						exrom            <= 1'b1;
						game             <= 1'b0;
						state.iof_ena    <= 1'b1;
						state.iof_wr_ena <= 1'b1;
						state.bank_lo    <= '0;
						state.bank_hi    <= '0;
					end
					if (ioe_wr) begin
						if (addr_in[1]) begin	// $DE02 control register
							game  <= ~data_in[0] & data_in[2];	// Boot jumper bit 2
							exrom <= ~data_in[1];
						end else begin	// $DE00 bank register
							state.bank_lo <= data_in[5:0];
							state.bank_hi <= data_in[5:0];
						end
					end
				end

				default: begin
					exrom <= 1'b1;
					game  <= 1'b1;
				end
			endcase
		end
	end

endmodule

//--- rtl/addr_translate.sv
/*
	Redirects CPU accesses to the cartridge image in SDRAM. ROM windows go
	to the page of the current bank, the IO2 page to the cartridge RAM.
	Everything else passes through unchanged.
*/

`timescale 1ns/10ps

module addr_translate import cart_pkg::*, mem_map_pkg::*; (
	input  logic           rom_l,
	input  logic           rom_h,
	input  logic           iof,
	input  logic           mem_write,
	input  logic           exrom,
	input  logic           game,
	input  cpu_addr_t      addr_in,
	bank_state_if.translator  state,
	page_lookup_if.translator lookup,
	output sdram_addr_t    addr_out,
	output logic           mem_write_out
);

	logic cs_iof;
	logic ultimax;

	// Page inside the ROM region plus the window offset
	function automatic sdram_addr_t rom_addr(input page_t page, input cpu_addr_t ofs);
		rom_addr = (sdram_addr_t'(1) << ROM_BASE_BIT) |
			sdram_addr_t'({page, ofs[WIN_BITS-1:0]});
	endfunction

	assign lookup.lo_idx = state.bank_lo;
	assign lookup.hi_idx = state.bank_hi;

	assign cs_iof  = iof && (mem_write ? state.iof_wr_ena : state.iof_ena);
	assign ultimax = exrom && !game;

	// ****************************************
	// Address redirection
	// ****************************************
	always_comb begin
		addr_out = sdram_addr_t'(addr_in);

		if (rom_l && !mem_write)
			addr_out = rom_addr(lookup.lo_page, addr_in);
		if (rom_h && !mem_write)
			addr_out = rom_addr(lookup.hi_page, addr_in);

		if (cs_iof)	// $DFxx cartridge RAM
			addr_out = RAM_BASE + sdram_addr_t'(addr_in[IO_RAM_BITS-1:0]);
	end

	// No RAM under ROML in ultimax, so drop the write
	assign mem_write_out = mem_write && !(rom_l && ultimax);

endmodule

//--- rtl/cartridge.sv
/*
	Cartridge core top level. Takes the CRT bank records during load and the
	CPU memory signals at run time, returns the SDRAM address and the
	EXROM/GAME lines.
*/

`timescale 1ns/10ps

module cartridge import cart_pkg::*, mem_map_pkg::*; (
	input  logic        clk32,
	input  logic        reset_n,

	// CRT file information
	input  cart_id_t    cart_id,
	input  logic [7:0]  cart_exrom,
	input  logic [7:0]  cart_game,
	input  logic [15:0] cart_bank_num,
	input  logic [15:0] cart_bank_laddr,
	input  logic [15:0] cart_bank_size,
	input  logic [24:0] cart_bank_raddr,
	input  logic        cart_bank_wr,

	// CPU side
	input  logic        rom_l,
	input  logic        rom_h,
	input  logic        ioe,
	input  logic        iof,
	input  logic        mem_write,
	input  cpu_addr_t   addr_in,
	input  logic [7:0]  data_in,

	output logic        exrom,
	output logic        game,
	output sdram_addr_t addr_out,
	output logic        mem_write_out
);

	page_lookup_if lookup_bus ();
	bank_state_if  state_bus ();

	bank_table u_bank_table (
		.clk32           (clk32),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_raddr (cart_bank_raddr),
		.lookup          (lookup_bus.tbl)
	);

	cart_mapper u_cart_mapper (
		.clk32      (clk32),
		.reset_n    (reset_n),
		.cart_id    (cart_id),
		.cart_exrom (cart_exrom),
		.cart_game  (cart_game),
		.ioe        (ioe),
		.mem_write  (mem_write),
		.addr_in    (addr_in),
		.data_in    (data_in),
		.exrom      (exrom),
		.game       (game),
		.state      (state_bus.mapper)
	);

	addr_translate u_addr_translate (
		.rom_l         (rom_l),
		.rom_h         (rom_h),
		.iof           (iof),
		.mem_write     (mem_write),
		.exrom         (exrom),
		.game          (game),
		.addr_in       (addr_in),
		.state         (state_bus.translator),
		.lookup        (lookup_bus.translator),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out)
	);

endmodule

//--- dv/tb_clock.sv
/*
	Clock and reset source for the cartridge testbench. Reset is held high
	for a fixed number of cycles, then released just after a rising edge.
*/

`timescale 1ns/10ps

module tb_clock #(
	parameter real PERIOD_NS    = 4.0,
	parameter int  RESET_CYCLES = 10
) (
	output logic clk32,
	output logic reset_n	// Active high
);

	initial begin
		clk32 = 1'b0;
		forever #(PERIOD_NS / 2.0) clk32 = ~clk32;
	end

	initial begin
		reset_n = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk32);
		#0.5 reset_n = 1'b0;	// Same offset as the other inputs
	end

endmodule

//--- dv/cartridge_tb.sv
/*
	Testbench for the cartridge core. Loads a random bank table, then walks
	the cartridge types and checks the SDRAM address and the EXROM/GAME lines.
*/

`timescale 1ns/10ps

module cartridge_tb import cart_pkg::*, mem_map_pkg::*; #(
	parameter int unsigned SEED = 32'h75c5
) ();

	localparam real CLK_NS      = 4.0;
	localparam int  TEST_CYCLES = 20 + (BANK_ENTRIES + 17) * 2 + 90;	// Reset, load, tests

	logic        clk32;
	logic        reset_n;
	cart_id_t    cart_id;
	logic [7:0]  cart_exrom;
	logic [7:0]  cart_game;
	logic [15:0] cart_bank_num;
	logic [15:0] cart_bank_laddr;
	logic [15:0] cart_bank_size;
	logic [24:0] cart_bank_raddr;
	logic        cart_bank_wr;
	logic        rom_l;
	logic        rom_h;
	logic        ioe;
	logic        iof;
	logic        mem_write;
	cpu_addr_t   addr_in;
	logic [7:0]  data_in;
	logic        exrom;
	logic        game;
	sdram_addr_t addr_out;
	logic        mem_write_out;

	page_t lo_model [BANK_ENTRIES];	// Expected table contents
	page_t hi_model [BANK_ENTRIES];
	logic  [7:0] ctrl_vals [4] = '{8'h04, 8'h07, 8'h02, 8'h05};
	logic  [1:0] ctrl_lines [4] = '{2'b11, 2'b00, 2'b00, 2'b10};	// {exrom, game} per write
	int    errors      = 0;
	int    prop_errors = 0;
	int    checks      = 0;
	int    tests       = 0;
	int    test_start  = 0;
	logic  reset_q     = 1'b0;

	tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) u_clock (.clk32(clk32), .reset_n(reset_n));

	cartridge UUT (.*);

	// ****************************************
	// Concurrent checks
	// ****************************************
	always_ff @(posedge clk32) reset_q <= reset_n;

	assert property (@(posedge clk32) reset_q |-> (exrom && game))
	else begin
		prop_errors++;
		$display("FAILED exrom/game in reset expected 1/1 actual %h/%h",
			$sampled(exrom), $sampled(game));
	end

	// ROML is read only in ultimax
	assert property (@(posedge clk32) (rom_l && exrom && !game) |-> !mem_write_out)
	else begin
		prop_errors++;
		$display("FAILED mem_write_out expected 0 actual %h", $sampled(mem_write_out));
	end

	initial begin
		#(TEST_CYCLES * CLK_NS * 2.0);
		$display("Timeout, the tests did not finish within %0d cycles", TEST_CYCLES * 2);
		$display("Checks failed");
		$finish;
	end

	// ****************************************
	// Stimulus and reference tasks
	// ****************************************
	task automatic next_cycle();
		@(posedge clk32);
		#0.5;
	endtask

	task automatic clear_cpu();
		rom_l     = 1'b0;
		rom_h     = 1'b0;
		ioe       = 1'b0;
		iof       = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// ROM region at 1M, then the 8K page, then the window offset
	function automatic logic [31:0] rom_expect(input page_t page, input cpu_addr_t ofs);
		return 32'h100000 + (32'(page) << WIN_BITS) + (32'(ofs) & 32'h1fff);
	endfunction

	task automatic load_bank(input logic [15:0] num, input logic [15:0] laddr,
			input logic [15:0] size, input logic [24:0] raddr);
		page_t page;
		page = raddr[19:13];
		next_cycle();
		cart_bank_num   = num;
		cart_bank_laddr = laddr;
		cart_bank_size  = size;
		cart_bank_raddr = raddr;
		cart_bank_wr    = 1'b1;
		next_cycle();
		cart_bank_wr = 1'b0;
		if (num < 16'(BANK_ENTRIES)) begin
			if (laddr <= LO_LOAD_LIMIT) begin
				lo_model[num[5:0]] = page;
				if (size > LO_BANK_SIZE)
					hi_model[num[5:0]] = page + 7'd1;	// 16K packet
			end else begin
				hi_model[num[5:0]] = page;
			end
		end
	endtask

	task automatic io_access(input logic wr, input cpu_addr_t addr, input logic [7:0] data);
		next_cycle();
		clear_cpu();
		ioe       = 1'b1;
		mem_write = wr;
		addr_in   = addr;
		data_in   = data;
		next_cycle();	// Register change lands on this edge
		clear_cpu();
	endtask

	task automatic rom_access(input logic lo, input page_t page, input cpu_addr_t ofs);
		next_cycle();
		clear_cpu();
		rom_l   = lo;
		rom_h   = !lo;
		addr_in = ofs;
		#1.5;
		check_value(lo ? "addr_out ROML" : "addr_out ROMH", rom_expect(page, ofs), 32'(addr_out));
	endtask

	task automatic check_lines(input logic exp_exrom, input logic exp_game);
		check_value("exrom", 32'(exp_exrom), 32'(exrom));
		check_value("game", 32'(exp_game), 32'(game));
	endtask

	task automatic select_type(input cart_id_t id);
		next_cycle();
		clear_cpu();
		cart_id = id;
		next_cycle();	// Restart
		next_cycle();	// Init
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors + prop_errors - test_start);
		test_start = errors + prop_errors;
	endtask

	// ****************************************
	// Test sequence
	// ****************************************
	initial begin
		int unsigned n;
		logic [24:0] raddr;

		void'($urandom(SEED));
		cart_id         = 16'hffff;	// Unknown type
		cart_exrom      = 8'h00;
		cart_game       = 8'h00;
		cart_bank_num   = '0;
		cart_bank_laddr = '0;
		cart_bank_size  = '0;
		cart_bank_raddr = '0;
		cart_bank_wr    = 1'b0;
		addr_in         = 18'h2abcd;
		data_in         = '0;
		clear_cpu();

		repeat (3) @(posedge clk32);
		#2;
		check_lines(1'b1, 1'b1);
		check_value("addr_out", 32'h2abcd, 32'(addr_out));
		@(negedge reset_n);
		#1.5;
		check_lines(1'b1, 1'b1);
		next_cycle();
		check_lines(1'b1, 1'b1);
		check_value("addr_out", 32'h2abcd, 32'(addr_out));
		end_test("unknown type reset");

		raddr = 25'($urandom);
		load_bank(16'd0, 16'h8000, 16'h4000, raddr);
		select_type(CART_GENERIC);
		check_lines(1'b0, 1'b0);
		rom_access(1'b1, raddr[19:13], 18'h01234);
		rom_access(1'b0, raddr[19:13] + 7'd1, 18'h3fedc);
		end_test("generic 16K");

		for (int b = 0; b < BANK_ENTRIES; b++)
			load_bank(16'(b), 16'h8000, 16'h4000, 25'($urandom));
		for (int b = 0; b < 16; b++)
			load_bank(16'(b * 4 + 1), 16'ha000, 16'h2000, 25'($urandom));
		load_bank(16'd67, 16'h8000, 16'h4000, 25'($urandom));	// Beyond the table so never stored

		select_type(CART_OCEAN);
		check_lines(1'b0, 1'b0);
		for (int i = 0; i < 6; i++) begin
			n = (i == 0) ? 3 : $urandom % BANK_ENTRIES;
			io_access(1'b1, 18'h0de00, {2'b11, 6'(n)});
			rom_access(1'b1, lo_model[n], 18'($urandom));
			rom_access(1'b0, hi_model[n], 18'($urandom));
		end
		end_test("ocean");

		select_type(CART_C64GS);
		check_lines(1'b0, 1'b1);
		n = 1 + $urandom % (BANK_ENTRIES - 1);
		io_access(1'b1, 18'h0de00 | 18'(n), ~8'(n));
		rom_access(1'b1, lo_model[n], 18'h00400);
		io_access(1'b0, 18'h0de3f, 8'h00);	// Any read goes back to bank 0
		rom_access(1'b1, lo_model[0], 18'h00400);
		select_type(CART_MAGIC_DESK);
		check_lines(1'b0, 1'b1);
		n = 1 + $urandom % (BANK_ENTRIES - 1);
		io_access(1'b1, 18'h0de00, 8'(n));
		rom_access(1'b1, lo_model[n], 18'h01ff0);
		check_value("exrom", 32'h0, 32'(exrom));
		io_access(1'b1, 18'h0de00, 8'h80 | 8'(n));
		check_value("exrom", 32'h1, 32'(exrom));
		end_test("c64gs and magic desk");

		select_type(CART_EASYFLASH);
		check_lines(1'b1, 1'b0);
		next_cycle();
		clear_cpu();
		rom_l     = 1'b1;
		mem_write = 1'b1;
		addr_in   = 18'h01000;
		#1.5;
		check_value("mem_write_out", 32'h0, 32'(mem_write_out));
		next_cycle();
		clear_cpu();
		iof     = 1'b1;
		addr_in = 18'h0df5a;
		#1.5;
		check_value("addr_out IO2 read", 32'(RAM_BASE) + 32'h5a, 32'(addr_out));
		next_cycle();
		clear_cpu();
		iof       = 1'b1;
		mem_write = 1'b1;
		addr_in   = 18'h0dfa5;
		#1.5;
		check_value("addr_out IO2 write", 32'(RAM_BASE) + 32'ha5, 32'(addr_out));
		check_value("mem_write_out", 32'h1, 32'(mem_write_out));
		for (int i = 0; i < 4; i++) begin
			io_access(1'b1, 18'h0de02, ctrl_vals[i]);
			check_lines(ctrl_lines[i][1], ctrl_lines[i][0]);
		end
		n = $urandom % BANK_ENTRIES;
		io_access(1'b1, 18'h0de00, 8'(n));
		rom_access(1'b1, lo_model[n], 18'h00a5a);
		end_test("easyflash");

		select_type(CART_OCEAN);
		io_access(1'b1, 18'h0de00, 8'd9);
		rom_access(1'b1, lo_model[9], 18'h00010);
		next_cycle();
		clear_cpu();
		cart_exrom = 8'h00;
		cart_game  = 8'h01;
		cart_id    = CART_GENERIC;
		next_cycle();
		check_lines(1'b1, 1'b1);	// Restart cycle looks like reset
		next_cycle();
		check_lines(1'b0, 1'b1);
		rom_access(1'b1, lo_model[0], 18'h00010);
		end_test("type change");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors + prop_errors);
		if (errors + prop_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- vlog.f
rtl/cart_pkg.sv
rtl/mem_map_pkg.sv
rtl/cart_ifs.sv
rtl/bank_table.sv
rtl/cart_mapper.sv
rtl/addr_translate.sv
rtl/cartridge.sv
dv/tb_clock.sv
dv/cartridge_tb.sv

//--- Makefile
# Verilator build and run of the cartridge core testbench

VERILATOR ?= verilator
TOP       ?= cartridge_tb
LINT_TOP  ?= cartridge
SEED      ?= 30149
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  := vlog.f

VFLAGS    := --timing --assert --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "All checks passed" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
